// ==== tb/program_vectors.txt ====
// header: word count, stall flag, expected v0, checked address, expected word
// then word count pairs of address and word; a zero count ends the list
// alu program, no stalls
00000013 00000000 00ffddcd bfc00000 24081234
bfc00000 24081234 bfc00004 3c09ff00 bfc00008 35290f0f bfc0000c 01095021
bfc00010 000a5103 bfc00014 000a5a02 bfc00018 01685823 bfc0001c 0148602a
bfc00020 0148682b bfc00024 000c6200 bfc00028 016c1026 bfc0002c 312ef00f
bfc00030 39ce00f1 bfc00034 2dcfffff bfc00038 29d8ffff bfc0003c 004f1021
bfc00040 00581025 bfc00044 004e1021 bfc00048 00000008
// store and load program, no stalls
0000000a 00000000 cafef01e 00001008 cafef00d
bfc00000 24081000 bfc00004 3c09cafe bfc00008 3529f00d bfc0000c ad090008
bfc00010 ad00000c bfc00014 8d020008 bfc00018 8d0afffc bfc0001c 004a1021
bfc00020 00000008 00000ffc 00000011
// branch and jump program, no stalls
00000011 00000000 bfc00121 bfc00018 0ff00010
bfc00000 24080005 bfc00004 24090005 bfc00008 11090002 bfc0000c 24020bad
bfc00010 00000008 bfc00014 15090005 bfc00018 0ff00010 bfc0001c 00491021
bfc00020 0bf00014 bfc00024 24020bad bfc00040 03e01021 bfc00044 03e00008
bfc00050 14400001 bfc00054 24020bad bfc00058 11000001 bfc0005c 24420100
bfc00060 00000008
// same three programs with random waitrequest
00000013 00000001 00ffddcd bfc00000 24081234
bfc00000 24081234 bfc00004 3c09ff00 bfc00008 35290f0f bfc0000c 01095021
bfc00010 000a5103 bfc00014 000a5a02 bfc00018 01685823 bfc0001c 0148602a
bfc00020 0148682b bfc00024 000c6200 bfc00028 016c1026 bfc0002c 312ef00f
bfc00030 39ce00f1 bfc00034 2dcfffff bfc00038 29d8ffff bfc0003c 004f1021
bfc00040 00581025 bfc00044 004e1021 bfc00048 00000008
0000000a 00000001 cafef01e 00001008 cafef00d
bfc00000 24081000 bfc00004 3c09cafe bfc00008 3529f00d bfc0000c ad090008
bfc00010 ad00000c bfc00014 8d020008 bfc00018 8d0afffc bfc0001c 004a1021
bfc00020 00000008 00000ffc 00000011
00000011 00000001 bfc00121 bfc00018 0ff00010
bfc00000 24080005 bfc00004 24090005 bfc00008 11090002 bfc0000c 24020bad
bfc00010 00000008 bfc00014 15090005 bfc00018 0ff00010 bfc0001c 00491021
bfc00020 0bf00014 bfc00024 24020bad bfc00040 03e01021 bfc00044 03e00008
bfc00050 14400001 bfc00054 24020bad bfc00058 11000001 bfc0005c 24420100
bfc00060 00000008
00000000

// ==== sources.f ====
source/mips_cpu_pkg.sv
source/mips_cpu_alu.sv
source/mips_cpu_alu_control.sv
source/mips_cpu_controller.sv
source/mips_cpu_register_file.sv
source/mips_cpu_bus.sv
tb/mips_cpu_bus_asserts.sv
tb/mips_cpu_bus_tb.sv

// ==== Makefile ====
VERILATOR  := verilator
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert
TOP        := mips_cpu_bus_tb
FILELIST   := sources.f
OBJ_DIR    := obj_dir
PASS_TEXT  := Test completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/mips_cpu_bus_tb.sv ====
`default_nettype none

module mips_cpu_bus_tb;
  import mips_cpu_pkg::*;

  logic       clk;
  logic       reset;
  logic       active;
  word_t      register_v0;
  word_t      address;
  logic       write;
  logic       read;
  logic       waitrequest;
  word_t      writedata;
  logic [3:0] byteenable;
  word_t      readdata;

  word_t       vec [0:511];
  word_t       mem [word_t];
  logic [15:0] lfsr;
  logic        stall_en;
  logic        first_read_seen;
  word_t       first_read_addr;
  int          error_count;
  int          check_count;
  int          test_count;
  int          watchdog_cycles;

  mips_cpu_bus dut_i (
    .clk         (clk),
    .reset       (reset),
    .active      (active),
    .register_v0 (register_v0),
    .address     (address),
    .write       (write),
    .read        (read),
    .waitrequest (waitrequest),
    .writedata   (writedata),
    .byteenable  (byteenable),
    .readdata    (readdata)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // galois lfsr with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // unwritten words read back as a pattern built from the address
  function automatic word_t read_word(input word_t addr);
    read_word = mem.exists(addr) ? mem[addr] : ({addr[15:0], addr[31:16]} ^ 32'h5A5A_C3C3);
  endfunction

  task automatic compare_word(input string name, input word_t expected, input word_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] t=%0t %s expected %08h actual %08h", $time, name, expected, actual);
    end
  endtask

  // slave with at least one wait state; stalls stretch it at random
  always @(posedge clk) begin : memory_model
    logic ready;
    ready = 1'b1;
    if (reset) begin
      waitrequest <= 1'b1;
    end else if (read || write) begin
      if (read && !first_read_seen) begin
        first_read_addr = address;
        first_read_seen = 1'b1;
      end
      if (waitrequest) begin
        if (stall_en) begin
          ready = lfsr[0];
          lfsr  = lfsr_step(lfsr);
        end
        waitrequest <= !ready;
        if (ready && read) begin
          readdata <= read_word(address);
        end
      end else begin
        if (write) begin
          mem[address] = writedata;
          compare_word("byteenable", 32'h0000_000F, {28'h0, byteenable});
        end
        waitrequest <= 1'b1;
      end
    end else begin
      waitrequest <= 1'b1;
    end
  end

  task automatic run_test(input int base);
    int n_words;
    n_words = int'(vec[base]);
    @(posedge clk);
    reset    <= 1'b1;
    stall_en <= vec[base+1][0];
    mem.delete();
    for (int i = 0; i < n_words; i++) begin
      mem[vec[base+5+2*i]] = vec[base+6+2*i];
    end
    first_read_seen = 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    compare_word("active after reset", 32'd1, {31'b0, active});
    while (active) begin
      @(negedge clk);
    end
    if (!first_read_seen) begin
      error_count++;
      $display("no instruction fetch was seen after reset at t=%0t", $time);
    end
    compare_word("first fetch address", 32'hBFC0_0000, first_read_addr);
    compare_word("register_v0", vec[base+2], register_v0);
    compare_word("memory word", vec[base+4], read_word(vec[base+3]));
    repeat (10) begin
      @(negedge clk);
      if (active) begin
        error_count++;
        $display("active came back after the core halted at t=%0t", $time);
      end
    end
  endtask

  initial begin : watchdog
    wait (watchdog_cycles != 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles before the programs halted", watchdog_cycles);
    $display("Test failed");
    $finish;
  end

  initial begin : main
    int ptr;
    int total_words;
    reset           = 1'b1;
    waitrequest     = 1'b1;
    readdata        = '0;
    stall_en        = 1'b0;
    lfsr            = 16'd31;
    first_read_seen = 1'b0;
    first_read_addr = '0;
    error_count     = 0;
    check_count     = 0;
    test_count      = 0;
    watchdog_cycles = 0;
    total_words     = 0;
    $readmemh("tb/program_vectors.txt", vec);
    ptr = 0;
    while (vec[ptr] != 0) begin
      total_words += int'(vec[ptr]);
      test_count++;
      ptr = ptr + 5 + 2 * int'(vec[ptr]);
    end
    watchdog_cycles = 200 * total_words + 100;
    ptr = 0;
    while (vec[ptr] != 0) begin
      run_test(ptr);
      ptr = ptr + 5 + 2 * int'(vec[ptr]);
    end
    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/mips_cpu_bus_asserts.sv ====
`default_nettype none

module mips_cpu_bus_asserts (
  input logic                clk,
  input logic                reset,
  input logic                active,
  input logic                read,
  input logic                write,
  input mips_cpu_pkg::word_t address
);

  // one transfer direction at a time
  read_write_exclusive: assert property (
    @(posedge clk) disable iff (reset) !(read && write)
  ) else $error("read and write are high in the same cycle");

  // only whole words are transferred
  address_aligned: assert property (
    @(posedge clk) disable iff (reset) (read || write) |-> (address[1:0] == 2'b00)
  ) else $error("bus address %h is not word aligned", address);

  // a halted core leaves the bus idle
  halted_bus_idle: assert property (
    @(posedge clk) disable iff (reset) !active |-> (!read && !write)
  ) else $error("bus transfer requested while the core is halted");

endmodule

bind mips_cpu_bus mips_cpu_bus_asserts asserts_i (
  .clk     (clk),
  .reset   (reset),
  .active  (active),
  .read    (read),
  .write   (write),
  .address (address)
);

`default_nettype wire

// ==== source/mips_cpu_bus.sv ====
`default_nettype none

module mips_cpu_bus (
  input  logic                clk,
  input  logic                reset,
  output logic                active,
  output mips_cpu_pkg::word_t register_v0,
  output mips_cpu_pkg::word_t address,
  output logic                write,
  output logic                read,
  input  logic                waitrequest,
  output mips_cpu_pkg::word_t writedata,
  output logic [3:0]          byteenable,
  input  mips_cpu_pkg::word_t readdata
);
  import mips_cpu_pkg::*;

  cpu_state_t  state;
  ctrl_t       ctrl;
  logic        three_state;
  instr_t      ir;
  word_t       pc;
  word_t       pc_next;
  word_t       pc_after;
  word_t       a_reg;
  word_t       b_reg;
  word_t       alu_out;
  word_t       jump_dest;
  word_t       rd_data_1;
  word_t       rd_data_2;
  word_t       alu_a;
  word_t       alu_b;
  word_t       alu_result;
  logic        condition;
  alu_func_t   alu_func;
  reg_addr_t   write_reg;
  word_t       write_data;
  logic        stall;
  logic        instr_end;
  logic        halt;
  logic        pc_en;
  logic [15:0] imm;
  word_t       imm_sext;
  word_t       imm_zext;
  word_t       jump_target;

  assign imm         = ir[15:0];
  assign imm_sext    = {{16{imm[15]}}, imm};
  assign imm_zext    = {16'h0000, imm};
  assign jump_target = {pc[31:28], ir[25:0], 2'b00};

  // memory states hold until the slave drops waitrequest
  assign stall = (ctrl.mem_read || ctrl.mem_write) && waitrequest;

  assign alu_a = ctrl.alu_src_a ? a_reg : pc;

  always_comb begin
    case (ctrl.alu_src_b)
      b_sel_reg:    alu_b = b_reg;
      b_sel_four:   alu_b = 32'd4;
      b_sel_sext:   alu_b = imm_sext;
      b_sel_branch: alu_b = {imm_sext[29:0], 2'b00};
      b_sel_zext:   alu_b = imm_zext;
      default:      alu_b = '0;
    endcase
  end

  always_comb begin
    case (ctrl.pc_source)
      pc_sel_alu:  pc_next = alu_result;
      pc_sel_jump: pc_next = jump_target;
      pc_sel_reg:  pc_next = a_reg;
      default:     pc_next = jump_dest;
    endcase
  end

  assign pc_en = (ctrl.pc_write && !stall) || ctrl.jump
                 || (ctrl.pc_write_cond && condition);
  assign pc_after = pc_en ? pc_next : pc;

  // stop once an instruction leaves the pc at address zero
  assign instr_end = (state == st_execute && three_state) || state == st_writeback;
  assign halt      = instr_end && !stall && pc_after == '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_fetch;
    end else if (halt) begin
      state <= st_halted;
    end else if (!stall) begin
      case (state)
        st_fetch:     state <= st_decode;
        st_decode:    state <= st_execute;
        st_execute:   state <= three_state ? st_fetch : st_writeback;
        st_writeback: state <= st_fetch;
        default:      state <= st_halted;
      endcase
    end
  end

  assign active = (state != st_halted);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_vector;
    end else if (pc_en) begin
      pc <= pc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.ir_write && !stall) begin
      ir <= readdata;
    end
    // operands and the branch or jump target, captured once per instruction
    if (state == st_decode) begin
      a_reg     <= rd_data_1;
      b_reg     <= rd_data_2;
      jump_dest <= pc_next;
    end
    if (ctrl.alu_out_en) begin
      alu_out <= alu_result;
    end
  end

  always_comb begin
    case (ctrl.reg_dst)
      dst_rd:  write_reg = ir.rd;
      dst_ra:  write_reg = reg_ra;
      default: write_reg = ir.rt;
    endcase
  end

  // load data goes straight from the bus in the cycle it is accepted
  assign write_data = ctrl.mem_to_reg ? readdata : alu_result;

  assign address    = ctrl.iord ? alu_out : pc;
  assign read       = ctrl.mem_read;
  assign write      = ctrl.mem_write;
  assign writedata  = b_reg;
  assign byteenable = 4'b1111;

  mips_cpu_controller controller_i (
    .state       (state),
    .opcode      (ir.opcode),
    .rt          (ir.rt),
    .funct       (ir.funct),
    .ctrl        (ctrl),
    .three_state (three_state)
  );

  mips_cpu_alu_control alu_control_i (
    .alu_class (ctrl.alu_class),
    .funct     (ir.funct),
    .alu_func  (alu_func)
  );

  mips_cpu_alu alu_i (
    .alu_func  (alu_func),
    .a         (alu_a),
    .b         (alu_b),
    .shamt     (ir.shamt),
    .result    (alu_result),
    .condition (condition)
  );

  mips_cpu_register_file register_file_i (
    .clk          (clk),
    .reset        (reset),
    .write_enable (ctrl.reg_write && !stall),
    .read_reg_1   (ir.rs),
    .read_reg_2   (ir.rt),
    .write_reg    (write_reg),
    .write_data   (write_data),
    .read_data_1  (rd_data_1),
    .read_data_2  (rd_data_2),
    .read_data_v0 (register_v0)
  );

endmodule

`default_nettype wire

// ==== source/mips_cpu_register_file.sv ====
`default_nettype none

module mips_cpu_register_file (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     write_enable,
  input  mips_cpu_pkg::reg_addr_t  read_reg_1,
  input  mips_cpu_pkg::reg_addr_t  read_reg_2,
  input  mips_cpu_pkg::reg_addr_t  write_reg,
  input  mips_cpu_pkg::word_t      write_data,
  output mips_cpu_pkg::word_t      read_data_1,
  output mips_cpu_pkg::word_t      read_data_2,
  output mips_cpu_pkg::word_t      read_data_v0
);
  import mips_cpu_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && write_reg != '0) begin
      // r0 stays at zero
      regs[write_reg] <= write_data;
    end
  end

  assign read_data_1  = regs[read_reg_1];
  assign read_data_2  = regs[read_reg_2];

  // v0 tap for the top level port
  assign read_data_v0 = regs[reg_v0];

endmodule

`default_nettype wire

// ==== source/mips_cpu_controller.sv ====
`default_nettype none

module mips_cpu_controller (
  input  mips_cpu_pkg::cpu_state_t state,
  input  mips_cpu_pkg::opcode_t    opcode,
  input  mips_cpu_pkg::reg_addr_t  rt,
  input  mips_cpu_pkg::funct_t     funct,
  output mips_cpu_pkg::ctrl_t      ctrl,
  output logic                     three_state
);
  import mips_cpu_pkg::*;

  logic is_jump;
  logic rt_live;

  assign is_jump = (opcode == op_j) || (opcode == op_jal);

  // I-type results aimed at r0 need no write cycle
  assign rt_live = (rt != '0);

  // only memory instructions go on to writeback
  assign three_state = (opcode != op_lw) && (opcode != op_sw);

  always_comb begin
    ctrl = '0;
    case (state)
      st_fetch: begin
        ctrl.mem_read  = 1'b1;
        ctrl.ir_write  = 1'b1;
        ctrl.pc_write  = 1'b1;
        ctrl.alu_src_b = b_sel_four;
        ctrl.alu_class = cls_add;
        ctrl.pc_source = pc_sel_alu;
      end
      st_decode: begin
        // pc already holds pc+4 here, so pc + offset*4 is the branch target
        ctrl.alu_src_b = b_sel_branch;
        ctrl.alu_class = cls_add;
        ctrl.pc_source = is_jump ? pc_sel_jump : pc_sel_alu;
      end
      st_execute: begin
        case (opcode)
          op_special: begin
            if (funct == fn_jr) begin
              ctrl.jump      = 1'b1;
              ctrl.pc_source = pc_sel_reg;
            end else begin
              ctrl.alu_src_a = 1'b1;
              ctrl.alu_src_b = b_sel_reg;
              ctrl.alu_class = cls_funct;
              ctrl.reg_dst   = dst_rd;
              ctrl.reg_write = 1'b1;
            end
          end
          op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui: begin
            ctrl.alu_src_a = 1'b1;
            ctrl.alu_src_b = b_sel_zext;
            ctrl.reg_dst   = dst_rt;
            ctrl.reg_write = rt_live;
            case (opcode)
              op_addiu: begin
                ctrl.alu_class = cls_add;
                ctrl.alu_src_b = b_sel_sext;
              end
              op_slti: begin
                ctrl.alu_class = cls_slt_imm;
                ctrl.alu_src_b = b_sel_sext;
              end
              op_sltiu: begin
                // sign extended, then compared unsigned
                ctrl.alu_class = cls_sltu_imm;
                ctrl.alu_src_b = b_sel_sext;
              end
              op_andi: ctrl.alu_class = cls_and_imm;
              op_ori:  ctrl.alu_class = cls_or_imm;
              op_xori: ctrl.alu_class = cls_xor_imm;
              default: ctrl.alu_class = cls_lui;
            endcase
          end
          op_beq, op_bne: begin
            ctrl.alu_src_a     = 1'b1;
            ctrl.alu_src_b     = b_sel_reg;
            ctrl.alu_class     = (opcode == op_beq) ? cls_cond_eq : cls_cond_ne;
            ctrl.pc_write_cond = 1'b1;
            ctrl.pc_source     = pc_sel_dest;
          end
          op_j: begin
            ctrl.jump      = 1'b1;
            ctrl.pc_source = pc_sel_dest;
          end
          op_jal: begin
            // link value is pc+4, passed through the ALU as pc + 0
            ctrl.jump      = 1'b1;
            ctrl.pc_source = pc_sel_dest;
            ctrl.alu_src_b = b_sel_zero;
            ctrl.alu_class = cls_add;
            ctrl.reg_dst   = dst_ra;
            ctrl.reg_write = 1'b1;
          end
          op_lw, op_sw: begin
            ctrl.alu_src_a  = 1'b1;
            ctrl.alu_src_b  = b_sel_sext;
            ctrl.alu_class  = cls_add;
            ctrl.alu_out_en = 1'b1;
          end
          default: ;
        endcase
      end
      st_writeback: begin
        ctrl.iord = 1'b1;
        if (opcode == op_lw) begin
          ctrl.mem_read   = 1'b1;
          ctrl.mem_to_reg = 1'b1;
          ctrl.reg_dst    = dst_rt;
          ctrl.reg_write  = rt_live;
        end else begin
          ctrl.mem_write = 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/mips_cpu_alu_control.sv ====
`default_nettype none

module mips_cpu_alu_control (
  input  mips_cpu_pkg::alu_class_t alu_class,
  input  mips_cpu_pkg::funct_t     funct,
  output mips_cpu_pkg::alu_func_t  alu_func
);
  import mips_cpu_pkg::*;

  always_comb begin
    case (alu_class)
      cls_funct: begin
        // R-type, operation comes from funct
        case (funct)
          fn_addu: alu_func = alu_add;
          fn_subu: alu_func = alu_sub;
          fn_and:  alu_func = alu_and;
          fn_or:   alu_func = alu_or;
          fn_xor:  alu_func = alu_xor;
          fn_slt:  alu_func = alu_slt;
          fn_sltu: alu_func = alu_sltu;
          fn_sll:  alu_func = alu_sll;
          fn_srl:  alu_func = alu_srl;
          fn_sra:  alu_func = alu_sra;
          default: alu_func = alu_add;
        endcase
      end
      cls_sub:      alu_func = alu_sub;
      cls_and_imm:  alu_func = alu_and;
      cls_or_imm:   alu_func = alu_or;
      cls_xor_imm:  alu_func = alu_xor;
      cls_slt_imm:  alu_func = alu_slt;
      cls_sltu_imm: alu_func = alu_sltu;
      cls_lui:      alu_func = alu_lui;
      cls_cond_eq:  alu_func = alu_eq;
      cls_cond_ne:  alu_func = alu_ne;
      default:      alu_func = alu_add;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/mips_cpu_alu.sv ====
`default_nettype none

module mips_cpu_alu (
  input  mips_cpu_pkg::alu_func_t alu_func,
  input  mips_cpu_pkg::word_t     a,
  input  mips_cpu_pkg::word_t     b,
  input  mips_cpu_pkg::shamt_t    shamt,
  output mips_cpu_pkg::word_t     result,
  output logic                    condition
);
  import mips_cpu_pkg::*;

  logic lt_signed;
  logic lt_unsigned;

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (alu_func)
      alu_add: result = a + b;
      // compares still give the difference on result
      alu_sub, alu_eq, alu_ne: begin
        result = a - b;
      end
      alu_and: result = a & b;
      alu_or:  result = a | b;
      alu_xor: result = a ^ b;
      alu_slt: begin
        result = {31'b0, lt_signed};
      end
      alu_sltu: begin
        result = {31'b0, lt_unsigned};
      end
      // shifts act on the rt operand
      alu_sll: result = b << shamt;
      alu_srl: result = b >> shamt;
      alu_sra: begin
        result = word_t'($signed(b) >>> shamt);
      end
      alu_lui: begin
        result = {b[15:0], 16'h0000};
      end
      default: result = a + b;
    endcase
  end

  // branch taken flag for beq, flipped for bne
  assign condition = (a == b) ^ (alu_func == alu_ne);

endmodule

`default_nettype wire

// ==== source/mips_cpu_pkg.sv ====
`default_nettype none

package mips_cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;
  typedef logic [4:0]  shamt_t;

  // R-type layout; immediate is bits 15:0 and jump target bits 25:0
  typedef struct packed {
    opcode_t   opcode;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    shamt_t    shamt;
    funct_t    funct;
  } instr_t;

  typedef enum logic [2:0] {
    st_halted,
    st_fetch,
    st_decode,
    st_execute,
    st_writeback
  } cpu_state_t;

  // what the controller asks of the ALU, before funct is looked at
  typedef enum logic [3:0] {
    cls_add, cls_sub, cls_funct, cls_and_imm, cls_or_imm, cls_xor_imm,
    cls_slt_imm, cls_sltu_imm, cls_lui, cls_cond_eq, cls_cond_ne
  } alu_class_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_sltu,
    alu_sll, alu_srl, alu_sra, alu_lui, alu_eq, alu_ne
  } alu_func_t;

  typedef struct packed {
    logic       pc_write;
    logic       pc_write_cond;
    logic       jump;
    logic       iord;
    logic       ir_write;
    logic       mem_read;
    logic       mem_write;
    logic       mem_to_reg;
    logic       reg_write;
    logic [1:0] reg_dst;
    logic       alu_src_a;
    logic [2:0] alu_src_b;
    logic [1:0] pc_source;
    logic       alu_out_en;
    alu_class_t alu_class;
  } ctrl_t;

  localparam word_t     reset_vector = 32'hBFC0_0000;
  localparam reg_addr_t reg_v0       = 5'd2;
  localparam reg_addr_t reg_ra       = 5'd31;

  localparam opcode_t op_special = 6'h00;
  localparam opcode_t op_j       = 6'h02;
  localparam opcode_t op_jal     = 6'h03;
  localparam opcode_t op_beq     = 6'h04;
  localparam opcode_t op_bne     = 6'h05;
  localparam opcode_t op_addiu   = 6'h09;
  localparam opcode_t op_slti    = 6'h0a;
  localparam opcode_t op_sltiu   = 6'h0b;
  localparam opcode_t op_andi    = 6'h0c;
  localparam opcode_t op_ori     = 6'h0d;
  localparam opcode_t op_xori    = 6'h0e;
  localparam opcode_t op_lui     = 6'h0f;
  localparam opcode_t op_lw      = 6'h23;
  localparam opcode_t op_sw      = 6'h2b;

  localparam funct_t fn_sll  = 6'h00;
  localparam funct_t fn_srl  = 6'h02;
  localparam funct_t fn_sra  = 6'h03;
  localparam funct_t fn_jr   = 6'h08;
  localparam funct_t fn_addu = 6'h21;
  localparam funct_t fn_subu = 6'h23;
  localparam funct_t fn_and  = 6'h24;
  localparam funct_t fn_or   = 6'h25;
  localparam funct_t fn_xor  = 6'h26;
  localparam funct_t fn_slt  = 6'h2a;
  localparam funct_t fn_sltu = 6'h2b;

  // ALU operand b selects
  localparam logic [2:0] b_sel_reg    = 3'd0;
  localparam logic [2:0] b_sel_four   = 3'd1;
  localparam logic [2:0] b_sel_sext   = 3'd2;
  localparam logic [2:0] b_sel_branch = 3'd3;
  localparam logic [2:0] b_sel_zext   = 3'd4;
  localparam logic [2:0] b_sel_zero   = 3'd5;

  // next pc selects
  localparam logic [1:0] pc_sel_alu  = 2'd0;
  localparam logic [1:0] pc_sel_jump = 2'd1;
  localparam logic [1:0] pc_sel_reg  = 2'd2;
  localparam logic [1:0] pc_sel_dest = 2'd3;

  // destination register selects
  localparam logic [1:0] dst_rt = 2'd0;
  localparam logic [1:0] dst_rd = 2'd1;
  localparam logic [1:0] dst_ra = 2'd2;

endpackage

`default_nettype wire
